/* rtl/dmmu_defines.svh */
`ifndef DMMU_DEFINES_SVH
`define DMMU_DEFINES_SVH

// ------------------------------------------------------------
// address and page number widths (sv32)
// ------------------------------------------------------------
`define DMMU_VLEN 32
`define DMMU_PLEN 34
`define DMMU_PPNW 22
`define DMMU_VPNW 20

// number of data TLB entries, power of two, at least 2
`define DMMU_TLB_ENTRIES 4

// pte flag bit positions
`define DMMU_PTE_R 1
`define DMMU_PTE_W 2
`define DMMU_PTE_U 4
`define DMMU_PTE_D 7

// load/store privilege codes
`define DMMU_PRIV_U 2'd0
`define DMMU_PRIV_S 2'd1

// exception cause codes
`define DMMU_CAUSE_LD_MISALIGNED 4'd4
`define DMMU_CAUSE_ST_MISALIGNED 4'd6
`define DMMU_CAUSE_LD_PAGE_FAULT 4'd13
`define DMMU_CAUSE_ST_PAGE_FAULT 4'd15

`endif

/* rtl/dmmu_pkg.sv */
`include "dmmu_defines.svh"

package dmmu_pkg;

    // ------------------------------------------------------------
    // address types
    // ------------------------------------------------------------

    // virtual address as issued by the load/store unit
    typedef logic [`DMMU_VLEN-1:0] vaddr_t;

    // physical address, two bits wider than the virtual one in sv32
    typedef logic [`DMMU_PLEN-1:0] paddr_t;

    // virtual page number, vaddr[31:12]
    // upper 10 bits index level 1, lower 10 bits level 0
    typedef logic [`DMMU_VPNW-1:0] vpn_t;

    // ------------------------------------------------------------
    // page table entry
    // ------------------------------------------------------------

    // sv32 leaf pte
    // ppn in 31:10, rsw in 9:8, then d a g u x w r v in 7:0
    typedef logic [`DMMU_PPNW+9:0] pte_t;

    // ------------------------------------------------------------
    // control and status types
    // ------------------------------------------------------------

    // effective privilege of the load/store, only u and s used here
    typedef logic [1:0] priv_t;

    // exception cause code as reported to the lsu
    typedef logic [3:0] cause_t;

endpackage

/* rtl/dmmu_tlb.sv */
`timescale 1ns/1ps
`include "dmmu_defines.svh"

module dmmu_tlb #(
    parameter int unsigned NR_ENTRIES = `DMMU_TLB_ENTRIES
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    // drop every entry, the refill pointer stays where it is
    input  logic             flush_i,
    // lookup port, combinational
    input  logic             lu_req_i,
    input  dmmu_pkg::vaddr_t lu_vaddr_i,
    output logic             lu_hit_o,
    output dmmu_pkg::pte_t   lu_pte_o,
    output logic             lu_is_4m_o,
    // refill port, written at the next clock edge
    input  logic             upd_valid_i,
    input  dmmu_pkg::vpn_t   upd_vpn_i,
    input  dmmu_pkg::pte_t   upd_pte_i,
    input  logic             upd_is_4m_i
);

    localparam int unsigned PTR_W = $clog2(NR_ENTRIES);

    // level 1 part of the vpn, the only part compared on a megapage
    localparam int unsigned VPN1_LSB = `DMMU_VPNW / 2;

    // ------------------------------------------------------------
    // entry storage
    // ------------------------------------------------------------
    logic [NR_ENTRIES-1:0] valid_q;
    dmmu_pkg::vpn_t        vpn_q   [NR_ENTRIES];
    dmmu_pkg::pte_t        pte_q   [NR_ENTRIES];
    logic [NR_ENTRIES-1:0] is_4m_q;

    // round-robin replacement pointer
    logic [PTR_W-1:0]      ptr_q;

    // lookup side
    dmmu_pkg::vpn_t        lu_vpn;
    logic [NR_ENTRIES-1:0] match;

    assign lu_vpn = lu_vaddr_i[`DMMU_VLEN-1:12];

    // ------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------

    // per-entry compare
    // a 4 KiB entry needs all vpn bits, a 4 MiB entry only vpn[1]
    always_comb begin : entry_match
        for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
            match[i] = lu_req_i && valid_q[i]
                       && (vpn_q[i][`DMMU_VPNW-1:VPN1_LSB] == lu_vpn[`DMMU_VPNW-1:VPN1_LSB])
                       && (is_4m_q[i] || (vpn_q[i][VPN1_LSB-1:0] == lu_vpn[VPN1_LSB-1:0]));
        end
    end

    // pick the lowest matching entry
    // refill never creates duplicates in normal use, this only makes the
    // result deterministic if software maps the same page twice
    always_comb begin : hit_select
        logic found;
        found      = 1'b0;
        lu_pte_o   = '0;
        lu_is_4m_o = 1'b0;
        for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
            if (match[i] && !found) begin
                found      = 1'b1;
                lu_pte_o   = pte_q[i];
                lu_is_4m_o = is_4m_q[i];
            end
        end
        lu_hit_o = found;
    end

    // ------------------------------------------------------------
    // refill and flush
    // ------------------------------------------------------------

    // valid bits and replacement pointer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else begin
            if (flush_i) begin
                valid_q <= '0;
            end
            // a refill together with a flush keeps the new entry
            if (upd_valid_i) begin
                valid_q[ptr_q] <= 1'b1;
                ptr_q          <= ptr_q + 1'b1;
            end
        end
    end

    // entry contents, only meaningful while the valid bit is set
    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            vpn_q[ptr_q]   <= upd_vpn_i;
            pte_q[ptr_q]   <= upd_pte_i;
            is_4m_q[ptr_q] <= upd_is_4m_i;
        end
    end

endmodule

/* rtl/dmmu_req_stage.sv */
`timescale 1ns/1ps

module dmmu_req_stage (
    input  logic             clk_i,
    input  logic             rst_ni,
    // request in the lookup cycle
    input  logic             req_i,
    input  dmmu_pkg::vaddr_t vaddr_i,
    input  logic             is_store_i,
    input  logic             misaligned_i,
    input  logic             en_trans_i,
    // tlb lookup result of the same cycle
    input  logic             hit_i,
    input  dmmu_pkg::pte_t   pte_i,
    input  logic             is_4m_i,
    // registered copy for the result cycle
    output logic             req_q_o,
    output dmmu_pkg::vaddr_t vaddr_q_o,
    output logic             is_store_q_o,
    output logic             misaligned_q_o,
    output logic             en_trans_q_o,
    output logic             hit_q_o,
    output dmmu_pkg::pte_t   pte_q_o,
    output logic             is_4m_q_o
);

    // ------------------------------------------------------------
    // control flags
    // ------------------------------------------------------------

    // misaligned only counts together with a request,
    // otherwise an idle cycle would raise a stray exception
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q_o        <= 1'b0;
            misaligned_q_o <= 1'b0;
            en_trans_q_o   <= 1'b0;
            hit_q_o        <= 1'b0;
        end else begin
            req_q_o        <= req_i;
            misaligned_q_o <= misaligned_i & req_i;
            en_trans_q_o   <= en_trans_i;
            hit_q_o        <= hit_i & req_i;
        end
    end

    // ------------------------------------------------------------
    // request payload
    // ------------------------------------------------------------

    // captured only with a request
    // the result stage looks at these only while req_q_o is set
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            vaddr_q_o    <= vaddr_i;
            is_store_q_o <= is_store_i;
            pte_q_o      <= pte_i;
            is_4m_q_o    <= is_4m_i;
        end
    end

endmodule

/* rtl/dmmu_fault_check.sv */
`timescale 1ns/1ps
`include "dmmu_defines.svh"

module dmmu_fault_check (
    // registered request from the request stage
    input  logic              req_q_i,
    input  dmmu_pkg::vaddr_t  vaddr_q_i,
    input  logic              is_store_q_i,
    input  logic              misaligned_q_i,
    input  logic              en_trans_q_i,
    input  logic              hit_q_i,
    input  dmmu_pkg::pte_t    pte_q_i,
    input  logic              is_4m_q_i,
    // privilege context, held stable by the lsu
    input  dmmu_pkg::priv_t   priv_i,
    input  logic              sum_i,
    // result of the previous cycle's request
    output logic              valid_o,
    output dmmu_pkg::paddr_t  paddr_o,
    output logic              exc_valid_o,
    output dmmu_pkg::cause_t  exc_cause_o,
    output dmmu_pkg::vaddr_t  exc_tval_o,
    output logic              miss_o
);

    logic access_err;
    logic store_err;

    // ------------------------------------------------------------
    // physical address
    // ------------------------------------------------------------

    // bare mode zero-extends, sv32 joins ppn and page offset
    // megapage keeps vpn[0] from the virtual address
    always_comb begin : paddr_form
        paddr_o = {{(`DMMU_PLEN-`DMMU_VLEN){1'b0}}, vaddr_q_i};
        if (en_trans_q_i) begin
            paddr_o = {pte_q_i[`DMMU_PPNW+9:10], vaddr_q_i[11:0]};
            if (is_4m_q_i) begin
                paddr_o[21:12] = vaddr_q_i[21:12];
            end
        end
    end

    // ------------------------------------------------------------
    // permission checks
    // ------------------------------------------------------------

    // u-mode needs a user page
    // s-mode may touch a user page only with sum set
    assign access_err = ((priv_i == `DMMU_PRIV_U) && !pte_q_i[`DMMU_PTE_U])
                     || ((priv_i == `DMMU_PRIV_S) && pte_q_i[`DMMU_PTE_U] && !sum_i);

    // a store additionally needs write permission and an already dirty page,
    // d is never set in hardware here
    assign store_err = !pte_q_i[`DMMU_PTE_W] || !pte_q_i[`DMMU_PTE_D] || access_err;

    // ------------------------------------------------------------
    // result and exception
    // ------------------------------------------------------------
    assign exc_tval_o = vaddr_q_i;

    always_comb begin : resolve
        valid_o     = 1'b0;
        exc_valid_o = 1'b0;
        exc_cause_o = '0;
        miss_o      = 1'b0;
        if (misaligned_q_i) begin
            // misaligned wins over anything the tlb says
            valid_o     = 1'b1;
            exc_valid_o = 1'b1;
            exc_cause_o = is_store_q_i ? `DMMU_CAUSE_ST_MISALIGNED
                                       : `DMMU_CAUSE_LD_MISALIGNED;
        end else if (req_q_i) begin
            if (!en_trans_q_i) begin
                valid_o = 1'b1;
            end else if (hit_q_i) begin
                valid_o = 1'b1;
                if (is_store_q_i && store_err) begin
                    exc_valid_o = 1'b1;
                    exc_cause_o = `DMMU_CAUSE_ST_PAGE_FAULT;
                end else if (!is_store_q_i && access_err) begin
                    exc_valid_o = 1'b1;
                    exc_cause_o = `DMMU_CAUSE_LD_PAGE_FAULT;
                end
            end else begin
                // no entry, lsu retries after a refill
                miss_o = 1'b1;
            end
        end
    end

endmodule

/* rtl/sv32_dmmu.sv */
`timescale 1ns/1ps

module sv32_dmmu (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              en_trans_i,
    // lsu request, cycle 0
    input  logic              req_i,
    input  dmmu_pkg::vaddr_t  vaddr_i,
    input  logic              is_store_i,
    input  logic              misaligned_i,
    output logic              dtlb_hit_o,
    // privilege context
    input  dmmu_pkg::priv_t   priv_i,
    input  logic              sum_i,
    // tlb refill
    input  logic              upd_valid_i,
    input  dmmu_pkg::vpn_t    upd_vpn_i,
    input  dmmu_pkg::pte_t    upd_pte_i,
    input  logic              upd_is_4m_i,
    // result, cycle 1
    output logic              valid_o,
    output dmmu_pkg::paddr_t  paddr_o,
    output logic              exc_valid_o,
    output dmmu_pkg::cause_t  exc_cause_o,
    output dmmu_pkg::vaddr_t  exc_tval_o,
    output logic              miss_o
);

    // lookup result
    logic             tlb_hit;
    dmmu_pkg::pte_t   tlb_pte;
    logic             tlb_is_4m;

    // registered request
    logic             req_q;
    dmmu_pkg::vaddr_t vaddr_q;
    logic             is_store_q;
    logic             misaligned_q;
    logic             en_trans_q;
    logic             hit_q;
    dmmu_pkg::pte_t   pte_q;
    logic             is_4m_q;

    // bare mode is always ready
    assign dtlb_hit_o = en_trans_i ? tlb_hit : 1'b1;

    // ------------------------------------------------------------
    // stage 0, tlb lookup
    // ------------------------------------------------------------
    dmmu_tlb dmmu_tlb_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .lu_req_i    (req_i),
        .lu_vaddr_i  (vaddr_i),
        .lu_hit_o    (tlb_hit),
        .lu_pte_o    (tlb_pte),
        .lu_is_4m_o  (tlb_is_4m),
        .upd_valid_i (upd_valid_i),
        .upd_vpn_i   (upd_vpn_i),
        .upd_pte_i   (upd_pte_i),
        .upd_is_4m_i (upd_is_4m_i)
    );

    // ------------------------------------------------------------
    // stage 1, request register
    // ------------------------------------------------------------
    dmmu_req_stage dmmu_req_stage_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_i          (req_i),
        .vaddr_i        (vaddr_i),
        .is_store_i     (is_store_i),
        .misaligned_i   (misaligned_i),
        .en_trans_i     (en_trans_i),
        .hit_i          (tlb_hit),
        .pte_i          (tlb_pte),
        .is_4m_i        (tlb_is_4m),
        .req_q_o        (req_q),
        .vaddr_q_o      (vaddr_q),
        .is_store_q_o   (is_store_q),
        .misaligned_q_o (misaligned_q),
        .en_trans_q_o   (en_trans_q),
        .hit_q_o        (hit_q),
        .pte_q_o        (pte_q),
        .is_4m_q_o      (is_4m_q)
    );

    // ------------------------------------------------------------
    // stage 2, fault resolution
    // ------------------------------------------------------------
    dmmu_fault_check dmmu_fault_check_inst (
        .req_q_i        (req_q),
        .vaddr_q_i      (vaddr_q),
        .is_store_q_i   (is_store_q),
        .misaligned_q_i (misaligned_q),
        .en_trans_q_i   (en_trans_q),
        .hit_q_i        (hit_q),
        .pte_q_i        (pte_q),
        .is_4m_q_i      (is_4m_q),
        .priv_i         (priv_i),
        .sum_i          (sum_i),
        .valid_o        (valid_o),
        .paddr_o        (paddr_o),
        .exc_valid_o    (exc_valid_o),
        .exc_cause_o    (exc_cause_o),
        .exc_tval_o     (exc_tval_o),
        .miss_o         (miss_o)
    );

endmodule

/* tests/tb_sv32_dmmu.sv */
`timescale 1ns/1ps

module tb_sv32_dmmu;

    localparam int MAX_RECS = 64;
    localparam logic [3:0] OP_REFILL = 4'h1;
    localparam logic [3:0] OP_FLUSH  = 4'h2;
    localparam logic [3:0] OP_REQ    = 4'h3;
    localparam logic [3:0] OP_END    = 4'hf;

    // ------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------
    logic             clk = 1'b0;
    logic             rst_n;
    logic             flush;
    logic             en_trans;
    logic             req;
    dmmu_pkg::vaddr_t vaddr;
    logic             is_store;
    logic             misaligned;
    dmmu_pkg::priv_t  priv;
    logic             sum;
    logic             upd_valid;
    dmmu_pkg::vpn_t   upd_vpn;
    dmmu_pkg::pte_t   upd_pte;
    logic             upd_is_4m;
    logic             dtlb_hit;
    logic             valid;
    dmmu_pkg::paddr_t paddr;
    logic             exc_valid;
    dmmu_pkg::cause_t exc_cause;
    dmmu_pkg::vaddr_t exc_tval;
    logic             miss;

    // one record per line with the fields packed from the top nibble down
    logic [135:0] recs [MAX_RECS];
    int           checks = 0;
    int           errors = 0;
    int           cycles = 0;
    int           cycle_limit = 4 * MAX_RECS + 50;
    integer       seed = 32'hf4db_e55a;

    sv32_dmmu sv32_dmmu_inst (
        .clk_i (clk), .rst_ni (rst_n), .flush_i (flush), .en_trans_i (en_trans),
        .req_i (req), .vaddr_i (vaddr), .is_store_i (is_store),
        .misaligned_i (misaligned), .dtlb_hit_o (dtlb_hit), .priv_i (priv),
        .sum_i (sum), .upd_valid_i (upd_valid), .upd_vpn_i (upd_vpn),
        .upd_pte_i (upd_pte), .upd_is_4m_i (upd_is_4m), .valid_o (valid),
        .paddr_o (paddr), .exc_valid_o (exc_valid), .exc_cause_o (exc_cause),
        .exc_tval_o (exc_tval), .miss_o (miss)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // watchdog on the cycle count
    // the limit follows the number of records
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence did not complete", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic check_value(input string test, input string field,
                               input logic [35:0] expected, input logic [35:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", test, field, expected, actual);
            errors++;
        end
    endtask

    // drop the strobes and keep privilege context and translation enable
    task automatic drive_idle();
        req        = 1'b0;
        is_store   = 1'b0;
        misaligned = 1'b0;
        flush      = 1'b0;
        upd_valid  = 1'b0;
    endtask

    task automatic run_record(input int idx);
        logic [135:0] r;
        string        test;
        r    = recs[idx];
        test = $sformatf("record %0d", idx);
        @(posedge clk);
        #1;
        drive_idle();
        case (r[135:132])
            OP_REFILL: begin
                upd_valid = 1'b1;
                upd_vpn   = r[123:104];
                upd_pte   = r[91:60];
                upd_is_4m = r[56];
            end
            OP_FLUSH: begin
                flush = 1'b1;
            end
            OP_REQ: begin
                req        = 1'b1;
                en_trans   = r[131];
                is_store   = r[130];
                misaligned = r[129];
                sum        = r[128];
                priv       = r[125:124];
                vaddr      = r[123:92];
            end
            default: begin
                $display("%s carries an unknown operation code %h", test, r[135:132]);
                errors++;
            end
        endcase
        if (r[135:132] == OP_REQ) begin
            // hit is combinational in the lookup cycle
            @(negedge clk);
            check_value(test, "dtlb_hit", 36'(r[52]), 36'(dtlb_hit));
            @(posedge clk);
            #1;
            drive_idle();
            // result cycle
            @(negedge clk);
            check_value(test, "valid", 36'(r[48]), 36'(valid));
            check_value(test, "exc_valid", 36'(r[8]), 36'(exc_valid));
            check_value(test, "miss", 36'(r[0]), 36'(miss));
            if (r[48] && !r[8]) begin
                check_value(test, "paddr", r[47:12], 36'(paddr));
            end
            if (r[8]) begin
                check_value(test, "exc_cause", 36'(r[7:4]), 36'(exc_cause));
                check_value(test, "exc_tval", 36'(r[123:92]), 36'(exc_tval));
            end
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin : main_seq
        int n_recs;
        int gap;
        rst_n     = 1'b0;
        en_trans  = 1'b0;
        vaddr     = '0;
        priv      = 2'd1;
        sum       = 1'b0;
        upd_vpn   = '0;
        upd_pte   = '0;
        upd_is_4m = 1'b0;
        drive_idle();
        // a misaligned translated request held through reset
        // must not reach the result registers
        req        = 1'b1;
        misaligned = 1'b1;
        en_trans   = 1'b1;
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = '1;
        end
        $readmemh("tests/dmmu_tests.mem", recs);
        n_recs = 0;
        while (n_recs < MAX_RECS && recs[n_recs][135:132] != OP_END) begin
            n_recs++;
        end
        cycle_limit = 4 * n_recs + 50;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        drive_idle();
        @(negedge clk);
        check_value("after reset", "valid", 36'h0, 36'(valid));
        check_value("after reset", "exc_valid", 36'h0, 36'(exc_valid));
        check_value("after reset", "miss", 36'h0, 36'(miss));
        for (int i = 0; i < n_recs; i++) begin
            run_record(i);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
                drive_idle();
            end
        end
        @(posedge clk);
        #1;
        drive_idle();
        $display("records: %0d, checks: %0d, errors: %0d", n_recs, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tests/dmmu_tests.mem */
// op_flags_priv_vaddr_pte_4m_hit_valid_paddr_exc_cause_miss, op 1 refill 2 flush 3 request f end
// flags bit3 en_trans bit2 store bit1 misaligned bit0 sum, refill vpn taken from vaddr[31:12]
3_0_1_80001234_00000000_0_1_1_080001234_0_0_0
3_4_1_fffffffc_00000000_0_1_1_0fffffffc_0_0_0
3_8_1_00401abc_00000000_0_0_0_000000000_0_0_1
1_0_0_00401000_ffffc4c7_0_0_0_000000000_0_0_0
3_8_1_00401abc_00000000_0_1_1_3ffff1abc_0_0_0
3_c_1_00401ff0_00000000_0_1_1_3ffff1ff0_0_0_0
1_0_0_80400000_aa9ffcd7_1_0_0_000000000_0_0_0
3_8_0_807ab123_00000000_0_1_1_2aa7ab123_0_0_0
3_8_0_00401abc_00000000_0_1_1_000000000_1_d_0
3_8_1_80400010_00000000_0_1_1_000000000_1_d_0
3_9_1_80400010_00000000_0_1_1_2aa400010_0_0_0
1_0_0_12345000_002af0c3_0_0_0_000000000_0_0_0
1_0_0_12346000_002af447_0_0_0_000000000_0_0_0
3_c_1_12345008_00000000_0_1_1_000000000_1_f_0
3_8_1_12345008_00000000_0_1_1_000abc008_0_0_0
3_c_1_12346004_00000000_0_1_1_000000000_1_f_0
3_c_0_00401000_00000000_0_1_1_000000000_1_f_0
3_a_1_55555001_00000000_0_0_1_000000000_1_4_0
3_e_1_12345002_00000000_0_1_1_000000000_1_6_0
1_0_0_0cafe000_000444c7_0_0_0_000000000_0_0_0
3_8_1_00401abc_00000000_0_0_0_000000000_0_0_1
3_8_1_0cafe7fc_00000000_0_1_1_0001117fc_0_0_0
3_8_1_12345008_00000000_0_1_1_000abc008_0_0_0
2_0_0_00000000_00000000_0_0_0_000000000_0_0_0
3_8_1_12345008_00000000_0_0_0_000000000_0_0_1
3_9_1_80400010_00000000_0_0_0_000000000_0_0_1
3_0_1_00000100_00000000_0_1_1_000000100_0_0_0
f_0_0_00000000_00000000_0_0_0_000000000_0_0_0

/* sources.f */
+incdir+rtl
rtl/dmmu_pkg.sv
rtl/dmmu_tlb.sv
rtl/dmmu_req_stage.sv
rtl/dmmu_fault_check.sv
rtl/sv32_dmmu.sv
tests/tb_sv32_dmmu.sv

/* run_verilator.sh */
#!/bin/sh
# build and run the dmmu testbench with verilator, result decided from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_sv32_dmmu -f sources.f \
    && ./obj_dir/Vtb_sv32_dmmu | tee sim.log
grep -q "^Verification passed$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
